//--- compile.f
design/memtest_pkg.sv
design/elapsed_timer.sv
design/test_ram.sv
design/mem_tester.sv
design/memtest_top.sv
dv/memtest_tb.sv

//--- run_sim.sh
#!/bin/sh

# build and run the memory tester testbench with verilator
cd "$(dirname "$0")" || exit 1

top=memtest_tb
build_log=build.log
sim_log=sim.log

verilator --binary --timing -Wno-fatal -f compile.f --top-module "$top" \
    -o "sim_$top" > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    cat "$build_log"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"sim_$top" > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -q "test failed" "$sim_log"; then
    exit 1
fi
exit 0

//--- dv/memtest_tb.sv
`timescale 1ns/1ps

module memtest_tb import memtest_pkg::*; ();

    localparam int          addr_w         = 4;
    localparam int          data_w         = 32;
    localparam int unsigned clocks_per_sec = 4;
    localparam int          pass_len       = (1 << (addr_w + 1)) + 2;  // cycles per pass
    localparam int          timeout_cycles = 4 * pass_len;
    localparam int          num_rows       = 7;

    logic              clk_gui;
    logic              timer_reset;
    logic              run;
    logic              fault_en;
    logic [addr_w-1:0] fault_addr;
    logic [data_w-1:0] fault_mask;
    count_t            pass_count;
    count_t            fail_count;
    logic [addr_w-1:0] last_fail_addr;
    logic              pass_done;
    secs_t             secs;
    bcd4_t             mins;
    logic [2:0]        led;

    int unsigned       cyc;          // edges since reset release
    logic [31:0]       lfsr_state;
    count_t            exp_pass;
    count_t            exp_fail;
    logic [addr_w-1:0] exp_fail_addr;

    // stimulus table with one entry per row
    string             row_name       [num_rows];
    logic              row_fault_en   [num_rows];
    logic [addr_w-1:0] row_fault_addr [num_rows];
    logic [data_w-1:0] row_fault_mask [num_rows];
    logic              row_rand       [num_rows];  // draw addr and mask from lfsr
    int                row_passes     [num_rows];

    memtest_top #(
        .addr_w         (addr_w),
        .data_w         (data_w),
        .clocks_per_sec (clocks_per_sec)
    ) memtest_top_inst (
        .clk_gui        (clk_gui),
        .timer_reset    (timer_reset),
        .run            (run),
        .fault_en       (fault_en),
        .fault_addr     (fault_addr),
        .fault_mask     (fault_mask),
        .pass_count     (pass_count),
        .fail_count     (fail_count),
        .last_fail_addr (last_fail_addr),
        .pass_done      (pass_done),
        .secs           (secs),
        .mins           (mins),
        .led            (led)
    );

    initial begin
        clk_gui = 1'b0;
        forever #20 clk_gui = ~clk_gui;  // 40 ns period
    end

    // reference cycle count for the timer
    always @(posedge clk_gui) begin
        if (timer_reset) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    // right shifting galois lfsr
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'hd000_0001;
        end
        return n;
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // binary minutes to four bcd digits
    function automatic bcd4_t to_bcd4(input int unsigned v);
        bcd4_t r;
        int unsigned x;
        x = v % 10000;  // display wraps after 9999
        for (int i = 0; i < 4; i++) begin
            r[4*i +: 4] = 4'(x % 10);
            x           = x / 10;
        end
        return r;
    endfunction

    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (act !== exp) begin
            fail_stop($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input logic [addr_w-1:0] exp,
                              input logic [addr_w-1:0] act);
        if (act !== exp) begin
            fail_stop($sformatf("mismatch %s: expected 0x%0h, actual 0x%0h", name, exp, act));
        end
    endtask

    task automatic check_secs(input string name, input secs_t exp, input secs_t act);
        if (act !== exp) begin
            fail_stop($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_mins(input string name, input bcd4_t exp, input bcd4_t act);
        if (act !== exp) begin
            fail_stop($sformatf("mismatch %s: expected %4h, actual %4h", name, exp, act));
        end
    endtask

    task automatic check_led(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (act !== exp) begin
            fail_stop($sformatf("mismatch %s: expected %3b, actual %3b", name, exp, act));
        end
    endtask

    // sample point 2 ns after the edge
    task automatic next_cycle();
        @(posedge clk_gui);
        #2;
    endtask

    // timer and leds against the cycle count
    task automatic check_status(input string name);
        secs_t exp_secs;
        exp_secs = secs_t'(cyc / clocks_per_sec);
        check_secs({name, " secs"}, exp_secs, secs);
        check_mins({name, " mins"}, to_bcd4(cyc / (60 * clocks_per_sec)), mins);
        check_led({name, " led"}, {exp_secs[0], exp_fail[1:0]}, led);
    endtask

    task automatic wait_pass_done(input string name);
        int            n;
        tester_state_e st;
        n = 0;
        do begin
            next_cycle();
            n++;
        end while (!pass_done && n < timeout_cycles);
        if (!pass_done) begin
            st = memtest_top_inst.mem_tester_inst.state;
            fail_stop($sformatf("timeout: no pass_done in %s after %0d cycles, tester in %s",
                                name, n, st.name()));
        end
        next_cycle();  // totals move at the end of st_check
        if (pass_done) begin
            fail_stop($sformatf("pass_done stayed high for more than one cycle in %s", name));
        end
    endtask

    // nothing may finish while run is low
    task automatic expect_idle(input string name, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            next_cycle();
            if (pass_done) begin
                fail_stop($sformatf("%s: pass_done pulsed while run was low", name));
            end
        end
    endtask

    // check one finished pass against the injected fault
    task automatic check_pass(input string name, input logic en, input logic [addr_w-1:0] fa,
                              input logic [data_w-1:0] fm);
        wait_pass_done(name);
        if (en && fm != '0) begin
            exp_fail++;
            exp_fail_addr = fa;  // only cell that reads back wrong
        end else begin
            exp_pass++;
        end
        check_count({name, " pass_count"}, exp_pass, pass_count);
        check_count({name, " fail_count"}, exp_fail, fail_count);
        check_addr({name, " last_fail_addr"}, exp_fail_addr, last_fail_addr);
        check_status(name);
    endtask

    task automatic set_row(input string name, input logic en, input logic [addr_w-1:0] fa,
                           input logic [data_w-1:0] fm, input logic rnd, input int passes,
                           input int idx);
        row_name[idx]       = name;
        row_fault_en[idx]   = en;
        row_fault_addr[idx] = fa;
        row_fault_mask[idx] = fm;
        row_rand[idx]       = rnd;
        row_passes[idx]     = passes;
    endtask

    task automatic build_table();
        logic [31:0] r;
        set_row("clean_start",       1'b0, 4'h0, 32'h0000_0000, 1'b0, 3, 0);
        set_row("fault_fixed",       1'b1, 4'h5, 32'h0000_0100, 1'b0, 2, 1);
        set_row("clean_after_fault", 1'b0, 4'h5, 32'h0000_0100, 1'b0, 2, 2);
        set_row("mask_zero",         1'b1, 4'h9, 32'h0000_0000, 1'b0, 1, 3);
        set_row("fault_lfsr_a",      1'b1, 4'h0, 32'h0000_0000, 1'b1, 2, 4);
        set_row("fault_lfsr_b",      1'b1, 4'h0, 32'h0000_0000, 1'b1, 1, 5);
        set_row("clean_end",         1'b0, 4'h0, 32'h0000_0000, 1'b0, 2, 6);
        for (int i = 0; i < num_rows; i++) begin
            if (row_rand[i]) begin
                take_bits(addr_w, r);
                row_fault_addr[i] = r[addr_w-1:0];
                take_bits(data_w, r);
                row_fault_mask[i] = r;
            end
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        timer_reset   = 1'b1;
        run           = 1'b0;
        fault_en      = 1'b0;
        fault_addr    = '0;
        fault_mask    = '0;
        lfsr_state    = 32'ha1ed;
        exp_pass      = '0;
        exp_fail      = '0;
        exp_fail_addr = '0;
        build_table();

        repeat (16) @(posedge clk_gui);
        #2;
        timer_reset = 1'b0;

        // everything cleared and tester parked
        check_count("reset pass_count", '0, pass_count);
        check_count("reset fail_count", '0, fail_count);
        check_addr("reset last_fail_addr", '0, last_fail_addr);
        check_status("reset");
        expect_idle("idle_after_reset", 2 * pass_len);
        check_status("idle_after_reset");

        // rows change right after a pass and before the next write sweep
        for (int i = 0; i < num_rows; i++) begin
            fault_en   = row_fault_en[i];
            fault_addr = row_fault_addr[i];
            fault_mask = row_fault_mask[i];
            run        = 1'b1;
            for (int p = 0; p < row_passes[i]; p++) begin
                check_pass(row_name[i], row_fault_en[i], row_fault_addr[i], row_fault_mask[i]);
            end
        end

        // the pass still finishes when run drops midway
        repeat (pass_len / 2) next_cycle();
        run = 1'b0;
        check_pass("run_drop", fault_en, fault_addr, fault_mask);
        expect_idle("idle_after_drop", 2 * pass_len);
        check_status("idle_after_drop");

        // long enough for minutes 9 -> 10
        for (int n = 0; n < 4000 && cyc < 2410; n++) begin
            next_cycle();
        end
        check_status("timer_carry");
        check_mins("timer_carry bcd", 16'h0010, mins);

        $display("test passed");
        $finish;
    end

endmodule

//--- design/memtest_top.sv
`timescale 1ns/1ps

module memtest_top import memtest_pkg::*; #(
    parameter int          addr_w         = 6,
    parameter int          data_w         = 32,
    parameter int unsigned clocks_per_sec = 27500000
) (
    input  logic              clk_gui,
    input  logic              timer_reset,
    input  logic              run,
    input  logic              fault_en,
    input  logic [addr_w-1:0] fault_addr,
    input  logic [data_w-1:0] fault_mask,
    output count_t            pass_count,
    output count_t            fail_count,
    output logic [addr_w-1:0] last_fail_addr,
    output logic              pass_done,
    output secs_t             secs,
    output bcd4_t             mins,
    output logic [2:0]        led
);

    localparam int unsigned clocks_per_min = 60 * clocks_per_sec;

    logic              ram_we;
    logic [addr_w-1:0] ram_addr;
    logic [data_w-1:0] ram_wdata;
    logic [data_w-1:0] ram_rdata;

    //////////////////////////////
    // tester and its ram
    //////////////////////////////

    mem_tester #(
        .addr_w (addr_w),
        .data_w (data_w)
    ) mem_tester_inst (
        .clk_gui        (clk_gui),
        .timer_reset    (timer_reset),
        .run            (run),
        .ram_we         (ram_we),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata),
        .ram_rdata      (ram_rdata),
        .pass_count     (pass_count),
        .fail_count     (fail_count),
        .last_fail_addr (last_fail_addr),
        .pass_done      (pass_done)
    );

    test_ram #(
        .addr_w (addr_w),
        .data_w (data_w)
    ) test_ram_inst (
        .clk_gui    (clk_gui),
        .we         (ram_we),
        .addr       (ram_addr),
        .wdata      (ram_wdata),
        .rdata      (ram_rdata),
        .fault_en   (fault_en),      // straight from the pins
        .fault_addr (fault_addr),
        .fault_mask (fault_mask)
    );

    //////////////////////////////
    // elapsed time
    //////////////////////////////

    elapsed_timer #(
        .clocks_per_sec (clocks_per_sec),
        .clocks_per_min (clocks_per_min)
    ) elapsed_timer_inst (
        .clk_gui     (clk_gui),
        .timer_reset (timer_reset),
        .secs        (secs),
        .mins        (mins)
    );

    // low fail bits plus a seconds heartbeat
    assign led = {secs[0], fail_count[1:0]};

endmodule

//--- design/mem_tester.sv
`timescale 1ns/1ps

module mem_tester import memtest_pkg::*; #(
    parameter int addr_w = 6,
    parameter int data_w = 32  // even width so the pattern splits in halves
) (
    input  logic              clk_gui,
    input  logic              timer_reset,
    input  logic              run,
    // ram port
    output logic              ram_we,
    output logic [addr_w-1:0] ram_addr,
    output logic [data_w-1:0] ram_wdata,
    input  logic [data_w-1:0] ram_rdata,
    // results
    output count_t            pass_count,
    output count_t            fail_count,
    output logic [addr_w-1:0] last_fail_addr,
    output logic              pass_done
);

    localparam int half_w = data_w / 2;

    tester_state_e state;

    // one extra bit so the read phase can count its trailing cycle
    logic [addr_w:0]   addr_cnt;
    count_t            pass_num;     // counts clean and failing passes alike
    logic [addr_w-1:0] rd_addr_q;    // address whose data is on ram_rdata
    logic              rd_valid_q;   // ram_rdata holds a word to compare
    logic              mismatch_q;   // sticky for the current pass
    logic [data_w-1:0] expect_data;
    logic              rd_mismatch;
    logic              last_addr;

    //////////////////////////////
    // test pattern
    //////////////////////////////

    // upper half carries the pass and lower half the address
    // odd passes invert every bit so each cell sees both polarities
    function automatic logic [data_w-1:0] pattern(
        input count_t            p,
        input logic [addr_w-1:0] a
    );
        logic [data_w-1:0] w;
        w = {half_w'(p), half_w'(a)};
        if (p[0]) begin
            w = ~w;
        end
        return w;
    endfunction

    //////////////////////////////
    // ram drive
    //////////////////////////////

    assign ram_addr  = addr_cnt[addr_w-1:0];  // wraps to 0 on the spare read cycle
    assign ram_we    = (state == st_write);
    assign ram_wdata = pattern(pass_num, ram_addr);

    // last word of the sweep
    assign last_addr = (addr_cnt[addr_w-1:0] == {addr_w{1'b1}});

    //////////////////////////////
    // fsm and address counter
    //////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            state    <= st_idle;
            addr_cnt <= '0;
        end else begin
            unique case (state)
                st_idle: begin
                    addr_cnt <= '0;
                    if (run) begin
                        state <= st_write;
                    end
                end
                st_write: begin
                    if (last_addr) begin
                        addr_cnt <= '0;  // read sweep starts at 0
                        state    <= st_read;
                    end else begin
                        addr_cnt <= addr_cnt + 1'b1;
                    end
                end
                st_read: begin
                    // top bit set means all reads issued and last data arriving now
                    if (addr_cnt[addr_w]) begin
                        addr_cnt <= '0;
                        state    <= st_check;
                    end else begin
                        addr_cnt <= addr_cnt + 1'b1;
                    end
                end
                st_check: begin
                    addr_cnt <= '0;
                    // run only matters here so a pass always runs to the end
                    state    <= run ? st_write : st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    //////////////////////////////
    // read pipeline and compare
    //////////////////////////////

    // track which address the ram is answering
    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= (state == st_read) && !addr_cnt[addr_w];
        end
    end

    always_ff @(posedge clk_gui) begin
        rd_addr_q <= ram_addr;  // address behind next cycle's ram_rdata
    end

    assign expect_data = pattern(pass_num, rd_addr_q);
    assign rd_mismatch = rd_valid_q && (ram_rdata != expect_data);

    //////////////////////////////
    // results
    //////////////////////////////

    // one cycle wide since st_check lasts one cycle
    assign pass_done = (state == st_check);

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            mismatch_q     <= 1'b0;
            last_fail_addr <= '0;
        end else begin
            if (state == st_check) begin
                mismatch_q <= 1'b0;  // fresh for the next pass
            end else if (rd_mismatch) begin
                mismatch_q <= 1'b1;
            end
            if (rd_mismatch) begin
                last_fail_addr <= rd_addr_q;  // latest one wins
            end
        end
    end

    // totals move at the end of st_check
    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            pass_count <= '0;
            fail_count <= '0;
            pass_num   <= '0;
        end else if (state == st_check) begin
            if (mismatch_q) begin
                fail_count <= fail_count + count_t'(1);
            end else begin
                pass_count <= pass_count + count_t'(1);
            end
            pass_num <= pass_num + count_t'(1);  // next pass flips polarity
        end
    end

endmodule

//--- design/test_ram.sv
`timescale 1ns/1ps

module test_ram #(
    parameter int addr_w = 6,
    parameter int data_w = 32
) (
    input  logic              clk_gui,
    input  logic              we,
    input  logic [addr_w-1:0] addr,
    input  logic [data_w-1:0] wdata,
    output logic [data_w-1:0] rdata,
    input  logic              fault_en,
    input  logic [addr_w-1:0] fault_addr,
    input  logic [data_w-1:0] fault_mask
);

    localparam int depth = 1 << addr_w;

    // storage, contents undefined after reset
    logic [data_w-1:0] mem [depth];

    logic              hit_fault;  // this write lands on the faulty cell
    logic [data_w-1:0] store_data;

    //////////////////////////////
    // fault injection
    //////////////////////////////

    // masked bits get flipped on the way in
    // so the cell reads back wrong until rewritten with fault_en low
    assign hit_fault  = fault_en && (addr == fault_addr);
    assign store_data = hit_fault ? (wdata ^ fault_mask) : wdata;

    //////////////////////////////
    // single port array
    //////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (we) begin
            mem[addr] <= store_data;
        end
        rdata <= mem[addr];  // one cycle read, old data on collision
    end

endmodule

//--- design/elapsed_timer.sv
`timescale 1ns/1ps

module elapsed_timer import memtest_pkg::*; #(
    parameter int unsigned clocks_per_sec = 27500000,
    parameter int unsigned clocks_per_min = 60 * 27500000
) (
    input  logic  clk_gui,
    input  logic  timer_reset,
    output secs_t secs,
    output bcd4_t mins
);

    // terminal values of the two prescalers
    localparam logic [31:0] sec_max = 32'(clocks_per_sec - 1);
    localparam logic [31:0] min_max = 32'(clocks_per_min - 1);

    logic [31:0] sec_div;  // cycles into the current second
    logic [31:0] min_div;  // cycles into the current minute

    // add one to a four digit bcd value
    // each digit rolls 9 -> 0 and carries upward, 9999 wraps to 0000
    function automatic bcd4_t bcd_inc(input bcd4_t v);
        bcd4_t       r;
        logic        carry;
        logic [3:0]  digit;
        r     = v;
        carry = 1'b1;
        for (int i = 0; i < 4; i++) begin
            digit = v[4*i +: 4];
            if (carry) begin
                if (digit == 4'd9) begin
                    r[4*i +: 4] = 4'd0;  // carry goes on
                end else begin
                    r[4*i +: 4] = digit + 4'd1;
                    carry       = 1'b0;
                end
            end
        end
        return r;
    endfunction

    //////////////////////////////
    // seconds, plain binary
    //////////////////////////////

    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            sec_div <= '0;
            secs    <= '0;
        end else if (sec_div == sec_max) begin
            sec_div <= '0;
            secs    <= secs + secs_t'(1);  // free wrap at 16 bits
        end else begin
            sec_div <= sec_div + 32'd1;
        end
    end

    //////////////////////////////
    // minutes, bcd
    //////////////////////////////

    // own prescaler, not chained off the seconds
    always_ff @(posedge clk_gui) begin
        if (timer_reset) begin
            min_div <= '0;
            mins    <= '0;
        end else if (min_div == min_max) begin
            min_div <= '0;
            mins    <= bcd_inc(mins);
        end else begin
            min_div <= min_div + 32'd1;
        end
    end

endmodule

//--- design/memtest_pkg.sv
package memtest_pkg;

    //////////////////////////////
    // counters and display values
    //////////////////////////////

    // pass and fail totals
    typedef logic [31:0] count_t;

    // four bcd minute digits, digit 0 in [3:0]
    typedef logic [15:0] bcd4_t;

    // binary seconds, wraps at 65535
    typedef logic [15:0] secs_t;

    //////////////////////////////
    // tester fsm
    //////////////////////////////

    typedef enum logic [1:0] {
        st_idle  = 2'd0,  // waiting for run
        st_write = 2'd1,  // one word per cycle
        st_read  = 2'd2,  // issue reads, compare returning data
        st_check = 2'd3   // update totals, pulse pass_done
    } tester_state_e;

endpackage
